/* Makefile */
TOP = tb_rv_decode

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
+incdir+verilog
verilog/decode_pkg.sv
verilog/opcode_classifier.sv
verilog/reg_name_lookup.sv
verilog/imm_generator.sv
verilog/mnemonic_rom.sv
verilog/rv_decode_top.sv
verif/tb_rv_decode.sv

/* verif/tb_rv_decode.sv */
`timescale 1ns/100ps
`include "decode_config.svh"

module tb_rv_decode;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int N_ENTRIES = 66;
	localparam int REPS = 4; // Random-field words per mnemonic
	localparam int N_ILLEGAL = 40;
	localparam int N_WORDS = N_ENTRIES * REPS + N_ILLEGAL;

	// Match patterns per mnemonic in the same order as NAMES
	localparam logic [31:0] BASES [N_ENTRIES] = '{
		32'h0000_0037, 32'h0000_0017, 32'h0000_006F, 32'h0000_0067,
		32'h0000_0063, 32'h0000_1063, 32'h0000_4063, 32'h0000_5063, 32'h0000_6063, 32'h0000_7063,
		32'h0000_0003, 32'h0000_1003, 32'h0000_2003, 32'h0000_3003, 32'h0000_4003, 32'h0000_5003,
		32'h0000_6003, 32'h0000_0023, 32'h0000_1023, 32'h0000_2023, 32'h0000_3023,
		32'h0000_0013, 32'h0000_2013, 32'h0000_3013, 32'h0000_4013, 32'h0000_6013, 32'h0000_7013,
		32'h0000_1013, 32'h0000_5013, 32'h4000_5013,
		32'h0000_0033, 32'h4000_0033, 32'h0000_1033, 32'h0000_2033, 32'h0000_3033,
		32'h0000_4033, 32'h0000_5033, 32'h4000_5033, 32'h0000_6033, 32'h0000_7033,
		32'h0000_000F, 32'h0000_100F, 32'h0000_0073, 32'h0010_0073,
		32'h0000_001B, 32'h0000_101B, 32'h0000_501B, 32'h4000_501B,
		32'h0000_003B, 32'h4000_003B, 32'h0000_103B, 32'h0000_503B, 32'h4000_503B,
		32'h0200_0033, 32'h0200_1033, 32'h0200_2033, 32'h0200_3033,
		32'h0200_4033, 32'h0200_5033, 32'h0200_6033, 32'h0200_7033,
		32'h0200_003B, 32'h0200_403B, 32'h0200_503B, 32'h0200_603B, 32'h0200_703B
	};
	localparam logic [63:0] NAMES [N_ENTRIES] = '{
		"lui", "auipc", "jal", "jalr",
		"beq", "bne", "blt", "bge", "bltu", "bgeu",
		"lb", "lh", "lw", "ld", "lbu", "lhu",
		"lwu", "sb", "sh", "sw", "sd",
		"addi", "slti", "sltiu", "xori", "ori", "andi",
		"slli", "srli", "srai",
		"add", "sub", "sll", "slt", "sltu",
		"xor", "srl", "sra", "or", "and",
		"fence", "fence.i", "ecall", "ebreak",
		"addiw", "slliw", "srliw", "sraiw",
		"addw", "subw", "sllw", "srlw", "sraw",
		"mul", "mulh", "mulhsu", "mulhu",
		"div", "divu", "rem", "remu",
		"mulw", "divw", "divuw", "remw", "remuw"
	};
	localparam logic [63:0] UNKNOWN_NAME = "unknown";
	localparam logic [31:0] REG_NAMES [32] = '{
		"zero", "ra", "sp", "gp", "tp", "t0", "t1", "t2",
		"s0", "s1", "a0", "a1", "a2", "a3", "a4", "a5",
		"a6", "a7", "s2", "s3", "s4", "s5", "s6", "s7",
		"s8", "s9", "s10", "s11", "t3", "t4", "t5", "t6"
	};

	logic clk = 1'b0;
	logic rst_n;
	logic inst_valid;
	logic [31:0] instruction;
	logic out_valid;
	decode_pkg::inst_format_e format;
	logic [7:0] flags;
	logic [63:0] name;
	logic [31:0] rd_name;
	logic [31:0] rs1_name;
	logic [31:0] rs2_name;
	logic [31:0] imm;

	logic exp_valid = 1'b0;
	logic started = 1'b0;
	decode_pkg::inst_format_e exp_format = decode_pkg::FMT_NONE;
	logic [7:0] exp_flags = '0;
	logic [63:0] exp_name = '0;
	logic [31:0] exp_rd = '0;
	logic [31:0] exp_rs1 = '0;
	logic [31:0] exp_rs2 = '0;
	logic [31:0] exp_imm = '0;
	int errors = 0;

	rv_decode_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.inst_valid(inst_valid),
		.instruction(instruction),
		.out_valid(out_valid),
		.format(format),
		.flags(flags),
		.name(name),
		.rd_name(rd_name),
		.rs1_name(rs1_name),
		.rs2_name(rs2_name),
		.imm(imm)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Bits a mnemonic leaves free for registers and immediates
	function automatic logic [31:0] field_mask(input logic [31:0] base);
		case (base[6:0])
			7'h37, 7'h17, 7'h6F: field_mask = 32'hFFFF_FF80;
			7'h33, 7'h3B: field_mask = 32'h01FF_8F80;
			7'h73: field_mask = 32'h0000_0000;
			7'h13: field_mask = (base[13:12] == 2'b01) ? 32'h03FF_8F80 : 32'hFFFF_8F80;
			7'h1B: field_mask = (base[13:12] == 2'b01) ? 32'h01FF_8F80 : 32'hFFFF_8F80;
			default: field_mask = 32'hFFFF_8F80;
		endcase
	endfunction

	function automatic int find_entry(input logic [31:0] word);
		int hit;
		hit = -1;
		for (int i = 0; i < N_ENTRIES; i++)
			if ((word & ~field_mask(BASES[i])) == BASES[i])
				hit = i;
		return hit;
	endfunction

	function automatic decode_pkg::inst_format_e format_of(input logic [6:0] opcode);
		case (opcode)
			7'h33, 7'h3B: format_of = decode_pkg::FMT_R;
			7'h03, 7'h13, 7'h1B, 7'h67: format_of = decode_pkg::FMT_I;
			7'h23: format_of = decode_pkg::FMT_S;
			7'h63: format_of = decode_pkg::FMT_B;
			7'h37, 7'h17: format_of = decode_pkg::FMT_U;
			7'h6F: format_of = decode_pkg::FMT_J;
			default: format_of = decode_pkg::FMT_SYS;
		endcase
	endfunction

	function automatic logic [7:0] flags_of(input logic [6:0] opcode,
		input decode_pkg::inst_format_e fmt);
		logic [7:0] f;
		f = '0;
		if (fmt == decode_pkg::FMT_NONE)
			f[`FLAG_ILLEGAL] = 1'b1;
		else
		begin
			f[`FLAG_LOAD] = (opcode == 7'h03);
			f[`FLAG_STORE] = (opcode == 7'h23);
			f[`FLAG_MEM] = f[`FLAG_LOAD] | f[`FLAG_STORE];
			f[`FLAG_BRANCH] = (fmt == decode_pkg::FMT_B);
			f[`FLAG_JUMP] = (opcode == 7'h6F) || (opcode == 7'h67);
			f[`FLAG_WORD] = (opcode == 7'h1B) || (opcode == 7'h3B);
		end
		return f;
	endfunction

	function automatic logic [31:0] imm_of(input logic [31:0] w,
		input decode_pkg::inst_format_e fmt);
		case (fmt)
			decode_pkg::FMT_I: imm_of = {{20{w[31]}}, w[31:20]};
			decode_pkg::FMT_S: imm_of = {{20{w[31]}}, w[31:25], w[11:7]};
			decode_pkg::FMT_B: imm_of = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			decode_pkg::FMT_U: imm_of = {w[31:12], 12'h000};
			decode_pkg::FMT_J: imm_of = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default: imm_of = '0;
		endcase
	endfunction

	function automatic logic [31:0] illegal_word();
		logic [31:0] w;
		do
		begin
			w = $urandom;
			if (w[31])
				w[1:0] = 2'b11; // Reach the 32-bit opcode space too
		end
		while (find_entry(w) >= 0);
		return w;
	endfunction

	task automatic report_mismatch(input string sig, input logic [63:0] expected,
		input logic [63:0] actual);
		errors++;
		$display("mismatch at %0t: %s expected %h got %h", $time, sig, expected, actual);
	endtask

	task automatic send_word(input logic [31:0] word);
		@(posedge clk);
		inst_valid <= 1'b1;
		instruction <= word;
		if ($urandom_range(3) == 0)
		begin
			@(posedge clk); // Occasional bubble between words
			inst_valid <= 1'b0;
		end
	endtask

	// One-deep expectation that lines up with out_valid on the next edge
	always @(posedge clk)
	begin : ref_model
		int idx;
		decode_pkg::inst_format_e fmt;
		idx = find_entry(instruction);
		fmt = (idx < 0) ? decode_pkg::FMT_NONE : format_of(instruction[6:0]);
		exp_valid <= inst_valid;
		if (inst_valid)
		begin
			started <= 1'b1;
			exp_format <= fmt;
			exp_name <= (idx < 0) ? UNKNOWN_NAME : NAMES[idx];
			exp_flags <= flags_of(instruction[6:0], fmt);
			exp_rd <= (fmt inside {decode_pkg::FMT_R, decode_pkg::FMT_I, decode_pkg::FMT_U,
				decode_pkg::FMT_J}) ? REG_NAMES[instruction[11:7]] : '0;
			exp_rs1 <= (fmt inside {decode_pkg::FMT_R, decode_pkg::FMT_I, decode_pkg::FMT_S,
				decode_pkg::FMT_B}) ? REG_NAMES[instruction[19:15]] : '0;
			exp_rs2 <= (fmt inside {decode_pkg::FMT_R, decode_pkg::FMT_S,
				decode_pkg::FMT_B}) ? REG_NAMES[instruction[24:20]] : '0;
			exp_imm <= imm_of(instruction, fmt);
		end
	end

	a_valid_timing: assert property (@(posedge clk) disable iff (!rst_n) out_valid == exp_valid)
		else report_mismatch("out_valid", $sampled(exp_valid), $sampled(out_valid));
	a_idle_flags: assert property (@(posedge clk) disable iff (!rst_n) !started |-> flags == '0)
		else report_mismatch("flags", 64'd0, $sampled(flags));
	a_name: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> name == exp_name)
		else report_mismatch("name", $sampled(exp_name), $sampled(name));
	a_format: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> format == exp_format)
		else report_mismatch("format", $sampled(exp_format), $sampled(format));
	a_flags: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> flags == exp_flags)
		else report_mismatch("flags", $sampled(exp_flags), $sampled(flags));
	a_rd: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> rd_name == exp_rd)
		else report_mismatch("rd_name", $sampled(exp_rd), $sampled(rd_name));
	a_rs1: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> rs1_name == exp_rs1)
		else report_mismatch("rs1_name", $sampled(exp_rs1), $sampled(rs1_name));
	a_rs2: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> rs2_name == exp_rs2)
		else report_mismatch("rs2_name", $sampled(exp_rs2), $sampled(rs2_name));
	a_imm: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> imm == exp_imm)
		else report_mismatch("imm", $sampled(exp_imm), $sampled(imm));

	initial
	begin
		#((2 * N_WORDS + RESET_CYCLES + 20) * CLK_PERIOD); // Each word takes at most two cycles
		$display("Watchdog expired before the test sequence finished");
		$display("Errors: %0d", errors + 1);
		$display("Done: errors found");
		$finish;
	end

	initial
	begin
		void'($urandom(42));
		rst_n = 1'b0;
		inst_valid = 1'b0;
		instruction = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		repeat (5) @(posedge clk); // Quiet window before the first word
		for (int i = 0; i < N_ENTRIES; i++)
			for (int r = 0; r < REPS; r++)
				send_word(BASES[i] | ($urandom & field_mask(BASES[i])));
		for (int k = 0; k < N_ILLEGAL; k++)
			send_word(illegal_word());
		@(posedge clk);
		inst_valid <= 1'b0;
		repeat (3) @(posedge clk);
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* verilog/decode_config.svh */
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

`define DEC_INST_WIDTH 32
`define DEC_IMM_WIDTH 32
`define DEC_REG_CHARS 4 // ABI names up to "zero"
`define DEC_NAME_CHARS 8 // Longest mnemonic is 7 chars
`define DEC_FLAG_WIDTH 8

`define FLAG_LOAD 0
`define FLAG_STORE 1
`define FLAG_BRANCH 2
`define FLAG_JUMP 3
`define FLAG_MEM 4
`define FLAG_WORD 5
`define FLAG_ILLEGAL 7 // Bit 6 stays zero

`endif

/* verilog/decode_pkg.sv */
package decode_pkg;

	typedef enum logic [2:0] {
		FMT_R,
		FMT_I,
		FMT_S,
		FMT_B,
		FMT_U,
		FMT_J,
		FMT_SYS, // Fence and environment calls
		FMT_NONE
	} inst_format_e;

	typedef enum logic [6:0] {
		MN_UNKNOWN = 7'd0,
		MN_LUI, MN_AUIPC, MN_JAL, MN_JALR,
		MN_BEQ, MN_BNE, MN_BLT, MN_BGE, MN_BLTU, MN_BGEU,
		MN_LB, MN_LH, MN_LW, MN_LD, MN_LBU, MN_LHU, MN_LWU,
		MN_SB, MN_SH, MN_SW, MN_SD,
		MN_ADDI, MN_SLTI, MN_SLTIU, MN_XORI, MN_ORI, MN_ANDI,
		MN_SLLI, MN_SRLI, MN_SRAI,
		MN_ADD, MN_SUB, MN_SLL, MN_SLT, MN_SLTU,
		MN_XOR, MN_SRL, MN_SRA, MN_OR, MN_AND,
		MN_FENCE, MN_FENCE_I, MN_ECALL, MN_EBREAK,
		MN_ADDIW, MN_SLLIW, MN_SRLIW, MN_SRAIW,
		MN_ADDW, MN_SUBW, MN_SLLW, MN_SRLW, MN_SRAW,
		MN_MUL, MN_MULH, MN_MULHSU, MN_MULHU,
		MN_DIV, MN_DIVU, MN_REM, MN_REMU,
		MN_MULW, MN_DIVW, MN_DIVUW, MN_REMW, MN_REMUW
	} mnemonic_e;

	// Same 32-bit word seen through each base format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm12;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_fmt;
		struct packed {
			logic imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic imm11;
			logic [6:0] opcode;
		} b_fmt;
		struct packed {
			logic [19:0] imm20;
			logic [4:0] rd;
			logic [6:0] opcode;
		} u_fmt;
		struct packed {
			logic imm20;
			logic [9:0] imm10_1;
			logic imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_fmt;
	} inst_word_u;

endpackage

/* verilog/imm_generator.sv */
`timescale 1ns/100ps
`include "decode_config.svh"

module imm_generator (
	input logic clk,
	input logic rst_n,
	input logic inst_valid,
	input decode_pkg::inst_word_u instruction,
	input decode_pkg::inst_format_e format_next,
	output logic [`DEC_IMM_WIDTH-1:0] imm
);

	logic [`DEC_IMM_WIDTH-1:0] imm_next;

	always_comb
	begin
		case (format_next)
			decode_pkg::FMT_I:
				imm_next = {{(`DEC_IMM_WIDTH-12){instruction.i_fmt.imm12[11]}},
					instruction.i_fmt.imm12};
			decode_pkg::FMT_S:
				imm_next = {{(`DEC_IMM_WIDTH-12){instruction.s_fmt.imm_hi[6]}},
					instruction.s_fmt.imm_hi, instruction.s_fmt.imm_lo};
			decode_pkg::FMT_B:
				imm_next = {{(`DEC_IMM_WIDTH-13){instruction.b_fmt.imm12}},
					instruction.b_fmt.imm12, instruction.b_fmt.imm11,
					instruction.b_fmt.imm10_5, instruction.b_fmt.imm4_1, 1'b0};
			decode_pkg::FMT_U:
				imm_next = {instruction.u_fmt.imm20, 12'h000}; // Upper 20 bits
			decode_pkg::FMT_J:
				imm_next = {{(`DEC_IMM_WIDTH-21){instruction.j_fmt.imm20}},
					instruction.j_fmt.imm20, instruction.j_fmt.imm19_12,
					instruction.j_fmt.imm11, instruction.j_fmt.imm10_1, 1'b0};
			default:
				imm_next = '0; // R, SYS and illegal words carry no immediate
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			imm <= '0;
		else if (inst_valid)
			imm <= imm_next;
	end

	a_offset_even: assert property (@(posedge clk) disable iff (!rst_n)
		(inst_valid && format_next inside {decode_pkg::FMT_B, decode_pkg::FMT_J}) |=>
		(imm[0] == 1'b0))
		else $error("imm_generator: odd branch or jump offset");

endmodule

/* verilog/mnemonic_rom.sv */
`timescale 1ns/100ps
`include "decode_config.svh"

module mnemonic_rom (
	input decode_pkg::mnemonic_e mnemonic,
	output logic [`DEC_NAME_CHARS*8-1:0] name
);

	// Text is right-aligned with zero upper bytes
	always_comb
	begin
		case (mnemonic)
			decode_pkg::MN_LUI: name = "lui";
			decode_pkg::MN_AUIPC: name = "auipc";
			decode_pkg::MN_JAL: name = "jal";
			decode_pkg::MN_JALR: name = "jalr";
			decode_pkg::MN_BEQ: name = "beq";
			decode_pkg::MN_BNE: name = "bne";
			decode_pkg::MN_BLT: name = "blt";
			decode_pkg::MN_BGE: name = "bge";
			decode_pkg::MN_BLTU: name = "bltu";
			decode_pkg::MN_BGEU: name = "bgeu";
			decode_pkg::MN_LB: name = "lb";
			decode_pkg::MN_LH: name = "lh";
			decode_pkg::MN_LW: name = "lw";
			decode_pkg::MN_LD: name = "ld";
			decode_pkg::MN_LBU: name = "lbu";
			decode_pkg::MN_LHU: name = "lhu";
			decode_pkg::MN_LWU: name = "lwu";
			decode_pkg::MN_SB: name = "sb";
			decode_pkg::MN_SH: name = "sh";
			decode_pkg::MN_SW: name = "sw";
			decode_pkg::MN_SD: name = "sd";
			decode_pkg::MN_ADDI: name = "addi";
			decode_pkg::MN_SLTI: name = "slti";
			decode_pkg::MN_SLTIU: name = "sltiu";
			decode_pkg::MN_XORI: name = "xori";
			decode_pkg::MN_ORI: name = "ori";
			decode_pkg::MN_ANDI: name = "andi";
			decode_pkg::MN_SLLI: name = "slli";
			decode_pkg::MN_SRLI: name = "srli";
			decode_pkg::MN_SRAI: name = "srai";
			decode_pkg::MN_ADD: name = "add";
			decode_pkg::MN_SUB: name = "sub";
			decode_pkg::MN_SLL: name = "sll";
			decode_pkg::MN_SLT: name = "slt";
			decode_pkg::MN_SLTU: name = "sltu";
			decode_pkg::MN_XOR: name = "xor";
			decode_pkg::MN_SRL: name = "srl";
			decode_pkg::MN_SRA: name = "sra";
			decode_pkg::MN_OR: name = "or";
			decode_pkg::MN_AND: name = "and";
			decode_pkg::MN_FENCE: name = "fence";
			decode_pkg::MN_FENCE_I: name = "fence.i";
			decode_pkg::MN_ECALL: name = "ecall";
			decode_pkg::MN_EBREAK: name = "ebreak";
			decode_pkg::MN_ADDIW: name = "addiw";
			decode_pkg::MN_SLLIW: name = "slliw";
			decode_pkg::MN_SRLIW: name = "srliw";
			decode_pkg::MN_SRAIW: name = "sraiw";
			decode_pkg::MN_ADDW: name = "addw";
			decode_pkg::MN_SUBW: name = "subw";
			decode_pkg::MN_SLLW: name = "sllw";
			decode_pkg::MN_SRLW: name = "srlw";
			decode_pkg::MN_SRAW: name = "sraw";
			decode_pkg::MN_MUL: name = "mul";
			decode_pkg::MN_MULH: name = "mulh";
			decode_pkg::MN_MULHSU: name = "mulhsu";
			decode_pkg::MN_MULHU: name = "mulhu";
			decode_pkg::MN_DIV: name = "div";
			decode_pkg::MN_DIVU: name = "divu";
			decode_pkg::MN_REM: name = "rem";
			decode_pkg::MN_REMU: name = "remu";
			decode_pkg::MN_MULW: name = "mulw";
			decode_pkg::MN_DIVW: name = "divw";
			decode_pkg::MN_DIVUW: name = "divuw";
			decode_pkg::MN_REMW: name = "remw";
			decode_pkg::MN_REMUW: name = "remuw";
			default: name = "unknown"; // MN_UNKNOWN and unused codes
		endcase
	end

endmodule

/* verilog/opcode_classifier.sv */
`timescale 1ns/100ps
`include "decode_config.svh"

module opcode_classifier (
	input logic clk,
	input logic rst_n,
	input logic inst_valid,
	input decode_pkg::inst_word_u instruction,
	output decode_pkg::inst_format_e format_next,
	output logic out_valid,
	output decode_pkg::inst_format_e format,
	output decode_pkg::mnemonic_e mnemonic,
	output logic [`DEC_FLAG_WIDTH-1:0] flags
);

	localparam logic [6:0] OP_LOAD = 7'h03;
	localparam logic [6:0] OP_MISC_MEM = 7'h0F;
	localparam logic [6:0] OP_IMM = 7'h13;
	localparam logic [6:0] OP_AUIPC = 7'h17;
	localparam logic [6:0] OP_IMM_32 = 7'h1B;
	localparam logic [6:0] OP_STORE = 7'h23;
	localparam logic [6:0] OP_OP = 7'h33;
	localparam logic [6:0] OP_LUI = 7'h37;
	localparam logic [6:0] OP_OP_32 = 7'h3B;
	localparam logic [6:0] OP_BRANCH = 7'h63;
	localparam logic [6:0] OP_JALR = 7'h67;
	localparam logic [6:0] OP_JAL = 7'h6F;
	localparam logic [6:0] OP_SYSTEM = 7'h73;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic legal;
	decode_pkg::mnemonic_e mn_next;
	logic [`DEC_FLAG_WIDTH-1:0] flags_next;

	assign opcode = instruction.r_fmt.opcode;
	assign funct3 = instruction.r_fmt.funct3;
	assign funct7 = instruction.r_fmt.funct7;

	always_comb
	begin
		mn_next = decode_pkg::MN_UNKNOWN;
		case (opcode)
			OP_LUI: mn_next = decode_pkg::MN_LUI;
			OP_AUIPC: mn_next = decode_pkg::MN_AUIPC;
			OP_JAL: mn_next = decode_pkg::MN_JAL;
			OP_JALR: if (funct3 == 3'b000) mn_next = decode_pkg::MN_JALR;
			OP_BRANCH:
			case (funct3)
				3'b000: mn_next = decode_pkg::MN_BEQ;
				3'b001: mn_next = decode_pkg::MN_BNE;
				3'b100: mn_next = decode_pkg::MN_BLT;
				3'b101: mn_next = decode_pkg::MN_BGE;
				3'b110: mn_next = decode_pkg::MN_BLTU;
				3'b111: mn_next = decode_pkg::MN_BGEU;
				default: mn_next = decode_pkg::MN_UNKNOWN;
			endcase
			OP_LOAD:
			case (funct3)
				3'b000: mn_next = decode_pkg::MN_LB;
				3'b001: mn_next = decode_pkg::MN_LH;
				3'b010: mn_next = decode_pkg::MN_LW;
				3'b011: mn_next = decode_pkg::MN_LD;
				3'b100: mn_next = decode_pkg::MN_LBU;
				3'b101: mn_next = decode_pkg::MN_LHU;
				3'b110: mn_next = decode_pkg::MN_LWU;
				default: mn_next = decode_pkg::MN_UNKNOWN;
			endcase
			OP_STORE:
			case (funct3)
				3'b000: mn_next = decode_pkg::MN_SB;
				3'b001: mn_next = decode_pkg::MN_SH;
				3'b010: mn_next = decode_pkg::MN_SW;
				3'b011: mn_next = decode_pkg::MN_SD;
				default: mn_next = decode_pkg::MN_UNKNOWN;
			endcase
			OP_IMM:
			case (funct3)
				3'b000: mn_next = decode_pkg::MN_ADDI;
				3'b010: mn_next = decode_pkg::MN_SLTI;
				3'b011: mn_next = decode_pkg::MN_SLTIU;
				3'b100: mn_next = decode_pkg::MN_XORI;
				3'b110: mn_next = decode_pkg::MN_ORI;
				3'b111: mn_next = decode_pkg::MN_ANDI;
				3'b001: if (funct7[6:1] == 6'h00) mn_next = decode_pkg::MN_SLLI; // 6-bit shamt
				3'b101:
				begin
					if (funct7[6:1] == 6'h00)
						mn_next = decode_pkg::MN_SRLI;
					else if (funct7[6:1] == 6'h10)
						mn_next = decode_pkg::MN_SRAI;
				end
			endcase
			OP_IMM_32:
			case ({funct7, funct3})
				{7'h00, 3'b001}: mn_next = decode_pkg::MN_SLLIW;
				{7'h00, 3'b101}: mn_next = decode_pkg::MN_SRLIW;
				{7'h20, 3'b101}: mn_next = decode_pkg::MN_SRAIW;
				default: if (funct3 == 3'b000) mn_next = decode_pkg::MN_ADDIW;
			endcase
			OP_OP:
			case ({funct7, funct3})
				{7'h00, 3'b000}: mn_next = decode_pkg::MN_ADD;
				{7'h20, 3'b000}: mn_next = decode_pkg::MN_SUB;
				{7'h00, 3'b001}: mn_next = decode_pkg::MN_SLL;
				{7'h00, 3'b010}: mn_next = decode_pkg::MN_SLT;
				{7'h00, 3'b011}: mn_next = decode_pkg::MN_SLTU;
				{7'h00, 3'b100}: mn_next = decode_pkg::MN_XOR;
				{7'h00, 3'b101}: mn_next = decode_pkg::MN_SRL;
				{7'h20, 3'b101}: mn_next = decode_pkg::MN_SRA;
				{7'h00, 3'b110}: mn_next = decode_pkg::MN_OR;
				{7'h00, 3'b111}: mn_next = decode_pkg::MN_AND;
				{7'h01, 3'b000}: mn_next = decode_pkg::MN_MUL;
				{7'h01, 3'b001}: mn_next = decode_pkg::MN_MULH;
				{7'h01, 3'b010}: mn_next = decode_pkg::MN_MULHSU;
				{7'h01, 3'b011}: mn_next = decode_pkg::MN_MULHU;
				{7'h01, 3'b100}: mn_next = decode_pkg::MN_DIV;
				{7'h01, 3'b101}: mn_next = decode_pkg::MN_DIVU;
				{7'h01, 3'b110}: mn_next = decode_pkg::MN_REM;
				{7'h01, 3'b111}: mn_next = decode_pkg::MN_REMU;
				default: mn_next = decode_pkg::MN_UNKNOWN;
			endcase
			OP_OP_32:
			case ({funct7, funct3})
				{7'h00, 3'b000}: mn_next = decode_pkg::MN_ADDW;
				{7'h20, 3'b000}: mn_next = decode_pkg::MN_SUBW;
				{7'h00, 3'b001}: mn_next = decode_pkg::MN_SLLW;
				{7'h00, 3'b101}: mn_next = decode_pkg::MN_SRLW;
				{7'h20, 3'b101}: mn_next = decode_pkg::MN_SRAW;
				{7'h01, 3'b000}: mn_next = decode_pkg::MN_MULW;
				{7'h01, 3'b100}: mn_next = decode_pkg::MN_DIVW;
				{7'h01, 3'b101}: mn_next = decode_pkg::MN_DIVUW;
				{7'h01, 3'b110}: mn_next = decode_pkg::MN_REMW;
				{7'h01, 3'b111}: mn_next = decode_pkg::MN_REMUW;
				default: mn_next = decode_pkg::MN_UNKNOWN;
			endcase
			OP_MISC_MEM:
			begin
				if (funct3 == 3'b000)
					mn_next = decode_pkg::MN_FENCE;
				else if (funct3 == 3'b001)
					mn_next = decode_pkg::MN_FENCE_I;
			end
			OP_SYSTEM:
			begin
				if (instruction == 32'h0000_0073)
					mn_next = decode_pkg::MN_ECALL;
				else if (instruction == 32'h0010_0073)
					mn_next = decode_pkg::MN_EBREAK; // CSR forms fall through as unknown
			end
			default: mn_next = decode_pkg::MN_UNKNOWN;
		endcase
	end

	always_comb
	begin
		format_next = decode_pkg::FMT_NONE;
		if (mn_next != decode_pkg::MN_UNKNOWN)
		begin
			case (opcode)
				OP_OP, OP_OP_32: format_next = decode_pkg::FMT_R;
				OP_LOAD, OP_IMM, OP_IMM_32, OP_JALR: format_next = decode_pkg::FMT_I;
				OP_STORE: format_next = decode_pkg::FMT_S;
				OP_BRANCH: format_next = decode_pkg::FMT_B;
				OP_LUI, OP_AUIPC: format_next = decode_pkg::FMT_U;
				OP_JAL: format_next = decode_pkg::FMT_J;
				default: format_next = decode_pkg::FMT_SYS; // Fence, ecall, ebreak
			endcase
		end
	end

	assign legal = (format_next != decode_pkg::FMT_NONE);

	always_comb
	begin
		flags_next = '0;
		flags_next[`FLAG_LOAD] = legal && (opcode == OP_LOAD);
		flags_next[`FLAG_STORE] = legal && (opcode == OP_STORE);
		flags_next[`FLAG_MEM] = flags_next[`FLAG_LOAD] || flags_next[`FLAG_STORE];
		flags_next[`FLAG_BRANCH] = (format_next == decode_pkg::FMT_B);
		flags_next[`FLAG_JUMP] = legal && (opcode == OP_JAL || opcode == OP_JALR);
		flags_next[`FLAG_WORD] = legal && (opcode == OP_IMM_32 || opcode == OP_OP_32);
		flags_next[`FLAG_ILLEGAL] = !legal;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			format <= decode_pkg::FMT_NONE;
			mnemonic <= decode_pkg::MN_UNKNOWN;
			flags <= '0;
		end
		else
		begin
			out_valid <= inst_valid;
			if (inst_valid)
			begin
				format <= format_next;
				mnemonic <= mn_next;
				flags <= flags_next;
			end
		end
	end

	a_illegal_iff_none: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (flags[`FLAG_ILLEGAL] == (format == decode_pkg::FMT_NONE)))
		else $error("opcode_classifier: illegal flag disagrees with format");

	a_load_store_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(flags[`FLAG_LOAD] && flags[`FLAG_STORE]))
		else $error("opcode_classifier: load and store both set");

	a_valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(inst_valid))
		else $error("opcode_classifier: out_valid without inst_valid");

endmodule

/* verilog/reg_name_lookup.sv */
`timescale 1ns/100ps
`include "decode_config.svh"

module reg_name_lookup (
	input logic clk,
	input logic rst_n,
	input logic inst_valid,
	input decode_pkg::inst_word_u instruction,
	input decode_pkg::inst_format_e format_next,
	output logic [`DEC_REG_CHARS*8-1:0] rd_name,
	output logic [`DEC_REG_CHARS*8-1:0] rs1_name,
	output logic [`DEC_REG_CHARS*8-1:0] rs2_name
);

	logic use_rd;
	logic use_rs1;
	logic use_rs2;

	function automatic logic [`DEC_REG_CHARS*8-1:0] abi_name(input logic [4:0] idx);
		case (idx)
			5'd0: abi_name = "zero";
			5'd1: abi_name = "ra";
			5'd2: abi_name = "sp";
			5'd3: abi_name = "gp";
			5'd4: abi_name = "tp";
			5'd5: abi_name = "t0";
			5'd6: abi_name = "t1";
			5'd7: abi_name = "t2";
			5'd8: abi_name = "s0";
			5'd9: abi_name = "s1";
			5'd10: abi_name = "a0";
			5'd11: abi_name = "a1";
			5'd12: abi_name = "a2";
			5'd13: abi_name = "a3";
			5'd14: abi_name = "a4";
			5'd15: abi_name = "a5";
			5'd16: abi_name = "a6";
			5'd17: abi_name = "a7";
			5'd18: abi_name = "s2";
			5'd19: abi_name = "s3";
			5'd20: abi_name = "s4";
			5'd21: abi_name = "s5";
			5'd22: abi_name = "s6";
			5'd23: abi_name = "s7";
			5'd24: abi_name = "s8";
			5'd25: abi_name = "s9";
			5'd26: abi_name = "s10";
			5'd27: abi_name = "s11";
			5'd28: abi_name = "t3";
			5'd29: abi_name = "t4";
			5'd30: abi_name = "t5";
			default: abi_name = "t6";
		endcase
	endfunction

	assign use_rd = format_next inside {decode_pkg::FMT_R, decode_pkg::FMT_I,
		decode_pkg::FMT_U, decode_pkg::FMT_J};
	assign use_rs1 = format_next inside {decode_pkg::FMT_R, decode_pkg::FMT_I,
		decode_pkg::FMT_S, decode_pkg::FMT_B};
	assign use_rs2 = format_next inside {decode_pkg::FMT_R, decode_pkg::FMT_S,
		decode_pkg::FMT_B};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_name <= '0;
			rs1_name <= '0;
			rs2_name <= '0;
		end
		else if (inst_valid)
		begin
			rd_name <= use_rd ? abi_name(instruction.r_fmt.rd) : '0; // Unused field reads blank
			rs1_name <= use_rs1 ? abi_name(instruction.r_fmt.rs1) : '0;
			rs2_name <= use_rs2 ? abi_name(instruction.r_fmt.rs2) : '0;
		end
	end

	a_none_blank: assert property (@(posedge clk) disable iff (!rst_n)
		(inst_valid && format_next == decode_pkg::FMT_NONE) |=>
		(rd_name == '0 && rs1_name == '0 && rs2_name == '0))
		else $error("reg_name_lookup: names not blank for illegal word");

endmodule

/* verilog/rv_decode_top.sv */
`timescale 1ns/100ps
`include "decode_config.svh"

module rv_decode_top (
	input logic clk,
	input logic rst_n,
	input logic inst_valid,
	input logic [`DEC_INST_WIDTH-1:0] instruction,
	output logic out_valid,
	output decode_pkg::inst_format_e format,
	output logic [`DEC_FLAG_WIDTH-1:0] flags,
	output logic [`DEC_NAME_CHARS*8-1:0] name,
	output logic [`DEC_REG_CHARS*8-1:0] rd_name,
	output logic [`DEC_REG_CHARS*8-1:0] rs1_name,
	output logic [`DEC_REG_CHARS*8-1:0] rs2_name,
	output logic [`DEC_IMM_WIDTH-1:0] imm
);

	decode_pkg::inst_format_e format_next; // Decoded once, shared by datapath
	decode_pkg::mnemonic_e mnemonic;

	opcode_classifier i_classifier (
		.clk(clk),
		.rst_n(rst_n),
		.inst_valid(inst_valid),
		.instruction(instruction),
		.format_next(format_next),
		.out_valid(out_valid),
		.format(format),
		.mnemonic(mnemonic),
		.flags(flags)
	);

	reg_name_lookup i_reg_names (
		.clk(clk),
		.rst_n(rst_n),
		.inst_valid(inst_valid),
		.instruction(instruction),
		.format_next(format_next),
		.rd_name(rd_name),
		.rs1_name(rs1_name),
		.rs2_name(rs2_name)
	);

	imm_generator i_imm (
		.clk(clk),
		.rst_n(rst_n),
		.inst_valid(inst_valid),
		.instruction(instruction),
		.format_next(format_next),
		.imm(imm)
	);

	mnemonic_rom i_name_rom (
		.mnemonic(mnemonic),
		.name(name)
	);

endmodule
